// File: npc_consts.svh
// Core-wide width and address constants, included by every unit that sizes data or registers
`ifndef NPC_CONSTS_SVH
`define NPC_CONSTS_SVH

// ==========================================================================
// Datapath
// ==========================================================================
`define NPC_XLEN      64              // Data and address width
`define NPC_RESET_PC  64'h8000_0000   // First fetch address

// ==========================================================================
// Register file
// ==========================================================================
`define NPC_NREGS     32              // Architectural registers
`define NPC_REG_AW    5               // Register index width
`define NPC_HALT_REG  10              // a0, reported as halt code

`endif

// File: rv_isa_pkg.sv
// RV64 instruction-set encodings shared by the decoder, the datapath and the testbench
`default_nettype none

`include "npc_consts.svh"

package rv_isa_pkg;

  // ==========================================================================
  // Major opcodes (inst[6:0])
  // ==========================================================================
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    SYSTEM = 7'b1110011
  } opcode_e;

  // Immediate layouts picked by the decoder
  typedef enum logic [2:0] {
    IMM_I    = 3'b000,
    IMM_U    = 3'b001,
    IMM_S    = 3'b010,
    IMM_B    = 3'b011,
    IMM_J    = 3'b100,
    IMM_NONE = 3'b111
  } imm_fmt_e;

  typedef logic [`NPC_REG_AW-1:0] reg_idx_t;

  // ==========================================================================
  // Function fields
  // ==========================================================================
  localparam logic [2:0]  F3_ADD     = 3'b000;  // addi, add, sub
  localparam logic [2:0]  F3_JALR    = 3'b000;
  localparam logic [2:0]  F3_PRIV    = 3'b000;  // ecall / ebreak group
  localparam logic [6:0]  F7_ADD     = 7'b0000000;
  localparam logic [6:0]  F7_SUB     = 7'b0100000;
  localparam logic [11:0] IMM_EBREAK = 12'h001;

  localparam int unsigned INST_BYTES = 4;       // Fixed 32-bit encoding

endpackage

`default_nettype wire

// File: npc_ctrl_pkg.sv
// Internal control types passed between decode, execute and writeback
`default_nettype none

`include "npc_consts.svh"

package npc_ctrl_pkg;

  // ==========================================================================
  // Datapath selects
  // ==========================================================================
  typedef enum logic [3:0] {
    ALU_ADD    = 4'b0000,
    ALU_SUB    = 4'b0001,
    ALU_PASS_B = 4'b0010,   // lui
    ALU_NONE   = 4'b1111
  } alu_op_e;

  typedef enum logic {
    SRC_A_RS1 = 1'b0,
    SRC_A_PC  = 1'b1
  } src_a_e;

  typedef enum logic [1:0] {
    SRC_B_RS2  = 2'b00,
    SRC_B_IMM  = 2'b01,
    SRC_B_FOUR = 2'b10    // Link address for jal / jalr
  } src_b_e;

  // ==========================================================================
  // Bundles
  // ==========================================================================
  typedef struct packed {
    alu_op_e alu_op;
    src_a_e  src_a;
    src_b_e  src_b;
    logic    wen;
    logic    jump;        // Target pc + imm
    logic    jump_reg;    // Target (rs1 + imm) & ~1
    logic    ebreak;
  } ctrl_t;

  typedef struct packed {
    logic                 valid;
    rv_isa_pkg::reg_idx_t rd;
    logic [`NPC_XLEN-1:0] data;
  } wb_t;

endpackage

`default_nettype wire

// File: npc_ifu.sv
// Fetch unit holding the PC; steps by four or takes a redirect, and freezes on halt
`timescale 1ns/1ns
`default_nettype none

`include "npc_consts.svh"

module npc_ifu (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_redirect,
  input  logic [`NPC_XLEN-1:0] i_target,
  input  logic                 i_halt,
  output logic [`NPC_XLEN-1:0] o_pc
);

  logic [`NPC_XLEN-1:0] pc_q;
  logic [`NPC_XLEN-1:0] pc_seq;
  logic [`NPC_XLEN-1:0] pc_next;

  // ==========================================================================
  // Next PC
  // ==========================================================================
  assign pc_seq  = pc_q + `NPC_XLEN'(4);
  assign pc_next = i_redirect ? i_target : pc_seq;  // jal / jalr win over sequential

  // ==========================================================================
  // PC register
  // ==========================================================================
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc_q <= `NPC_RESET_PC;
    end else if (!i_halt) begin   // Hold once the core has stopped
      pc_q <= pc_next;
    end
  end

  assign o_pc = pc_q;

endmodule

`default_nettype wire

// File: npc_idu.sv
// Instruction decoder; splits the word into register indices, immediate and control bundle
`timescale 1ns/1ns
`default_nettype none

`include "npc_consts.svh"

module npc_idu (
  input  logic [31:0]                 i_inst,
  output rv_isa_pkg::reg_idx_t        o_rs1,
  output rv_isa_pkg::reg_idx_t        o_rs2,
  output rv_isa_pkg::reg_idx_t        o_rd,
  output logic [`NPC_XLEN-1:0]        o_imm,
  output npc_ctrl_pkg::ctrl_t         o_ctrl
);

  rv_isa_pkg::opcode_e  opcode;
  rv_isa_pkg::imm_fmt_e imm_fmt;
  logic [2:0]           funct3;
  logic [6:0]           funct7;

  logic [`NPC_XLEN-1:0] imm_i;
  logic [`NPC_XLEN-1:0] imm_u;
  logic [`NPC_XLEN-1:0] imm_s;
  logic [`NPC_XLEN-1:0] imm_b;
  logic [`NPC_XLEN-1:0] imm_j;

  assign opcode = rv_isa_pkg::opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign o_rs1  = i_inst[19:15];
  assign o_rs2  = i_inst[24:20];
  assign o_rd   = i_inst[11:7];

  // ==========================================================================
  // Immediate layouts
  // ==========================================================================
  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    case (imm_fmt)
      rv_isa_pkg::IMM_I: o_imm = imm_i;
      rv_isa_pkg::IMM_U: o_imm = imm_u;
      rv_isa_pkg::IMM_S: o_imm = imm_s;
      rv_isa_pkg::IMM_B: o_imm = imm_b;
      rv_isa_pkg::IMM_J: o_imm = imm_j;
      default:           o_imm = '0;
    endcase
  end

  // ==========================================================================
  // Control decode
  // ==========================================================================
  always_comb begin
    // Anything not matched below retires as a no-op
    imm_fmt         = rv_isa_pkg::IMM_NONE;
    o_ctrl          = '0;
    o_ctrl.alu_op   = npc_ctrl_pkg::ALU_NONE;
    o_ctrl.src_a    = npc_ctrl_pkg::SRC_A_RS1;
    o_ctrl.src_b    = npc_ctrl_pkg::SRC_B_RS2;

    case (opcode)
      rv_isa_pkg::OP_IMM: begin
        if (funct3 == rv_isa_pkg::F3_ADD) begin         // addi
          imm_fmt       = rv_isa_pkg::IMM_I;
          o_ctrl.alu_op = npc_ctrl_pkg::ALU_ADD;
          o_ctrl.src_b  = npc_ctrl_pkg::SRC_B_IMM;
          o_ctrl.wen    = 1'b1;
        end
      end
      rv_isa_pkg::OP: begin
        if (funct3 == rv_isa_pkg::F3_ADD && funct7 == rv_isa_pkg::F7_ADD) begin
          o_ctrl.alu_op = npc_ctrl_pkg::ALU_ADD;
          o_ctrl.wen    = 1'b1;
        end else if (funct3 == rv_isa_pkg::F3_ADD && funct7 == rv_isa_pkg::F7_SUB) begin
          o_ctrl.alu_op = npc_ctrl_pkg::ALU_SUB;
          o_ctrl.wen    = 1'b1;
        end
      end
      rv_isa_pkg::LUI: begin
        imm_fmt       = rv_isa_pkg::IMM_U;
        o_ctrl.alu_op = npc_ctrl_pkg::ALU_PASS_B;
        o_ctrl.src_b  = npc_ctrl_pkg::SRC_B_IMM;
        o_ctrl.wen    = 1'b1;
      end
      rv_isa_pkg::AUIPC: begin
        imm_fmt       = rv_isa_pkg::IMM_U;
        o_ctrl.alu_op = npc_ctrl_pkg::ALU_ADD;
        o_ctrl.src_a  = npc_ctrl_pkg::SRC_A_PC;
        o_ctrl.src_b  = npc_ctrl_pkg::SRC_B_IMM;
        o_ctrl.wen    = 1'b1;
      end
      rv_isa_pkg::JAL: begin
        imm_fmt       = rv_isa_pkg::IMM_J;
        o_ctrl.alu_op = npc_ctrl_pkg::ALU_ADD;          // Link value pc + 4
        o_ctrl.src_a  = npc_ctrl_pkg::SRC_A_PC;
        o_ctrl.src_b  = npc_ctrl_pkg::SRC_B_FOUR;
        o_ctrl.wen    = 1'b1;
        o_ctrl.jump   = 1'b1;
      end
      rv_isa_pkg::JALR: begin
        if (funct3 == rv_isa_pkg::F3_JALR) begin
          imm_fmt         = rv_isa_pkg::IMM_I;
          o_ctrl.alu_op   = npc_ctrl_pkg::ALU_ADD;
          o_ctrl.src_a    = npc_ctrl_pkg::SRC_A_PC;
          o_ctrl.src_b    = npc_ctrl_pkg::SRC_B_FOUR;
          o_ctrl.wen      = 1'b1;
          o_ctrl.jump_reg = 1'b1;
        end
      end
      rv_isa_pkg::SYSTEM: begin
        // Only ebreak with all other fields zero
        if (i_inst[31:7] == {rv_isa_pkg::IMM_EBREAK, 5'b0, rv_isa_pkg::F3_PRIV, 5'b0}) begin
          o_ctrl.ebreak = 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: npc_regfile.sv
// Integer register file; two read ports, a fixed a0 port for the halt code, one write port
`timescale 1ns/1ns
`default_nettype none

`include "npc_consts.svh"

module npc_regfile (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic [`NPC_REG_AW-1:0]  i_raddr_a,
  input  logic [`NPC_REG_AW-1:0]  i_raddr_b,
  output logic [`NPC_XLEN-1:0]    o_rdata_a,
  output logic [`NPC_XLEN-1:0]    o_rdata_b,
  output logic [`NPC_XLEN-1:0]    o_halt_val,
  input  npc_ctrl_pkg::wb_t       i_wb
);

  logic [`NPC_XLEN-1:0] regs [`NPC_NREGS];

  // ==========================================================================
  // Write port
  // ==========================================================================
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `NPC_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb.valid && i_wb.rd != '0) begin  // x0 writes dropped
      regs[i_wb.rd] <= i_wb.data;
    end
  end

  // ==========================================================================
  // Read ports
  // ==========================================================================
  assign o_rdata_a  = (i_raddr_a == '0) ? '0 : regs[i_raddr_a];
  assign o_rdata_b  = (i_raddr_b == '0) ? '0 : regs[i_raddr_b];
  assign o_halt_val = regs[`NPC_HALT_REG];

endmodule

`default_nettype wire

// File: npc_exu.sv
// Execute unit; operand selection, ALU and jump target for the single-cycle datapath
`timescale 1ns/1ns
`default_nettype none

`include "npc_consts.svh"

module npc_exu (
  input  logic [`NPC_XLEN-1:0] i_pc,
  input  logic [`NPC_XLEN-1:0] i_rs1_val,
  input  logic [`NPC_XLEN-1:0] i_rs2_val,
  input  logic [`NPC_XLEN-1:0] i_imm,
  input  npc_ctrl_pkg::ctrl_t  i_ctrl,
  output logic [`NPC_XLEN-1:0] o_result,
  output logic                 o_redirect,
  output logic [`NPC_XLEN-1:0] o_target
);

  logic [`NPC_XLEN-1:0] op_a;
  logic [`NPC_XLEN-1:0] op_b;
  logic [`NPC_XLEN-1:0] reg_target;

  // ==========================================================================
  // Operand muxes
  // ==========================================================================
  assign op_a = (i_ctrl.src_a == npc_ctrl_pkg::SRC_A_PC) ? i_pc : i_rs1_val;

  always_comb begin
    case (i_ctrl.src_b)
      npc_ctrl_pkg::SRC_B_IMM:  op_b = i_imm;
      npc_ctrl_pkg::SRC_B_FOUR: op_b = `NPC_XLEN'(rv_isa_pkg::INST_BYTES);
      default:                  op_b = i_rs2_val;
    endcase
  end

  // ==========================================================================
  // ALU
  // ==========================================================================
  always_comb begin
    case (i_ctrl.alu_op)
      npc_ctrl_pkg::ALU_ADD:    o_result = op_a + op_b;
      npc_ctrl_pkg::ALU_SUB:    o_result = op_a - op_b;
      npc_ctrl_pkg::ALU_PASS_B: o_result = op_b;
      default:                  o_result = '0;
    endcase
  end

  // ==========================================================================
  // Jump target
  // ==========================================================================
  assign reg_target = (i_rs1_val + i_imm) & ~`NPC_XLEN'(1);  // jalr clears bit 0

  assign o_redirect = i_ctrl.jump | i_ctrl.jump_reg;
  assign o_target   = i_ctrl.jump_reg ? reg_target : (i_pc + i_imm);

endmodule

`default_nettype wire

// File: npc_wbu.sv
// Writeback unit; builds the register write and retire report, and latches the ebreak halt
`timescale 1ns/1ns
`default_nettype none

`include "npc_consts.svh"

module npc_wbu (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  rv_isa_pkg::reg_idx_t i_rd,
  input  npc_ctrl_pkg::ctrl_t  i_ctrl,
  input  logic [`NPC_XLEN-1:0] i_result,
  input  logic [`NPC_XLEN-1:0] i_halt_val,
  output npc_ctrl_pkg::wb_t    o_wb,
  output logic                 o_halt,
  output logic [`NPC_XLEN-1:0] o_halt_code
);

  logic                 halt_q;
  logic [`NPC_XLEN-1:0] halt_code_q;

  // ==========================================================================
  // Register write / retire report
  // ==========================================================================
  assign o_wb.valid = i_ctrl.wen & ~halt_q;  // Nothing retires after halt
  assign o_wb.rd    = i_rd;
  assign o_wb.data  = i_result;

  // ==========================================================================
  // Halt latch
  // ==========================================================================
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      halt_q      <= 1'b0;
      halt_code_q <= '0;
    end else if (i_ctrl.ebreak && !halt_q) begin
      halt_q      <= 1'b1;
      halt_code_q <= i_halt_val;     // a0 at the ebreak edge
    end
  end

  assign o_halt      = halt_q;
  assign o_halt_code = halt_code_q;

endmodule

`default_nettype wire

// File: npc_top.sv
// Core top level; connects fetch, decode, register file, execute and writeback
`timescale 1ns/1ns
`default_nettype none

`include "npc_consts.svh"

module npc_top (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic [31:0]          i_inst,
  output logic [`NPC_XLEN-1:0] o_inst_addr,
  output npc_ctrl_pkg::wb_t    o_wb,
  output logic                 o_halt,
  output logic [`NPC_XLEN-1:0] o_halt_code
);

  // ==========================================================================
  // Interconnect
  // ==========================================================================
  logic [`NPC_XLEN-1:0] pc;
  rv_isa_pkg::reg_idx_t rs1;
  rv_isa_pkg::reg_idx_t rs2;
  rv_isa_pkg::reg_idx_t rd;
  logic [`NPC_XLEN-1:0] imm;
  npc_ctrl_pkg::ctrl_t  ctrl;
  logic [`NPC_XLEN-1:0] rs1_val;
  logic [`NPC_XLEN-1:0] rs2_val;
  logic [`NPC_XLEN-1:0] halt_val;
  logic [`NPC_XLEN-1:0] result;
  logic                 redirect;
  logic [`NPC_XLEN-1:0] target;
  npc_ctrl_pkg::wb_t    wb;
  logic                 halt;

  npc_ifu ifu_inst (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_redirect (redirect),
    .i_target   (target),
    .i_halt     (halt),
    .o_pc       (pc)
  );

  npc_idu idu_inst (
    .i_inst (i_inst),
    .o_rs1  (rs1),
    .o_rs2  (rs2),
    .o_rd   (rd),
    .o_imm  (imm),
    .o_ctrl (ctrl)
  );

  npc_regfile regfile_inst (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_raddr_a  (rs1),
    .i_raddr_b  (rs2),
    .o_rdata_a  (rs1_val),
    .o_rdata_b  (rs2_val),
    .o_halt_val (halt_val),
    .i_wb       (wb)
  );

  npc_exu exu_inst (
    .i_pc       (pc),
    .i_rs1_val  (rs1_val),
    .i_rs2_val  (rs2_val),
    .i_imm      (imm),
    .i_ctrl     (ctrl),
    .o_result   (result),
    .o_redirect (redirect),
    .o_target   (target)
  );

  npc_wbu wbu_inst (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_rd        (rd),
    .i_ctrl      (ctrl),
    .i_result    (result),
    .i_halt_val  (halt_val),
    .o_wb        (wb),
    .o_halt      (halt),
    .o_halt_code (o_halt_code)
  );

  assign o_inst_addr = pc;
  assign o_wb        = wb;
  assign o_halt      = halt;

endmodule

`default_nettype wire

// File: tb_npc_top.sv
// Testbench for the core top level; plays instruction memory and checks retires against a model
`timescale 1ns/1ns
`default_nettype none

`include "npc_consts.svh"

module tb_npc_top;

  localparam logic [6:0]  OPC_OP_IMM  = 7'b0010011;
  localparam logic [6:0]  OPC_OP      = 7'b0110011;
  localparam logic [6:0]  OPC_LUI     = 7'b0110111;
  localparam logic [6:0]  OPC_AUIPC   = 7'b0010111;
  localparam logic [6:0]  OPC_JAL     = 7'b1101111;
  localparam logic [6:0]  OPC_JALR    = 7'b1100111;
  localparam logic [6:0]  OPC_SYSTEM  = 7'b1110011;
  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;
  localparam int          HOLD_CYCLES = 6;          // Cycles watched after the halt

  logic                 clk;
  logic                 rst_n;
  logic [31:0]          inst;
  logic [`NPC_XLEN-1:0] inst_addr;
  npc_ctrl_pkg::wb_t    wb;
  logic                 halt;
  logic [`NPC_XLEN-1:0] halt_code;

  // Stimulus table of name, word and expected register write
  string       row_name [$];
  logic [31:0] row_inst [$];
  bit          row_wen  [$];

  // Reference model
  logic [`NPC_XLEN-1:0] m_regs [32];
  logic [`NPC_XLEN-1:0] m_pc;
  logic                 m_halt;
  logic [`NPC_XLEN-1:0] m_halt_code;
  logic                 exp_valid;
  logic [4:0]           exp_rd;
  logic [`NPC_XLEN-1:0] exp_data;
  logic [`NPC_XLEN-1:0] exp_next;
  logic                 exp_ebreak;

  int mismatches = 0;
  int others     = 0;
  int cycles     = 0;
  int hold_cnt   = 0;
  int limit      = 0;
  bit finished   = 1'b0;

  npc_top npc_top_inst (
    .i_clk       (clk),
    .i_rst_n     (rst_n),
    .i_inst      (inst),
    .o_inst_addr (inst_addr),
    .o_wb        (wb),
    .o_halt      (halt),
    .o_halt_code (halt_code)
  );

  always #50 clk = ~clk;

  // ==========================================================================
  // Assembler helpers
  // ==========================================================================
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] asm_i(input logic [6:0] opc, input logic [4:0] rd,
                                        input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] asm_r(input logic [6:0] f7, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [4:0] rs2);
    return {f7, rs2, rs1, 3'b000, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] asm_u(input logic [6:0] opc, input logic [4:0] rd,
                                        input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] asm_jal(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  task automatic add_row(input string name, input logic [31:0] word, input bit wen);
    row_name.push_back(name);
    row_inst.push_back(word);
    row_wen.push_back(wen);
  endtask

  // Row index for an address, or -1 outside the program
  function automatic int row_of(input logic [`NPC_XLEN-1:0] addr);
    if (addr < `NPC_RESET_PC || addr[1:0] != 2'b00) return -1;
    if (addr >= `NPC_RESET_PC + 4 * row_inst.size()) return -1;
    return int'((addr - `NPC_RESET_PC) >> 2);
  endfunction

  function automatic logic [31:0] word_at(input logic [`NPC_XLEN-1:0] addr);
    return (row_of(addr) < 0) ? 32'h0000_0000 : row_inst[row_of(addr)];
  endfunction

  function automatic string name_at(input logic [`NPC_XLEN-1:0] addr);
    return (row_of(addr) < 0) ? "outside program" : row_name[row_of(addr)];
  endfunction

  function automatic bit wen_at(input logic [`NPC_XLEN-1:0] addr);
    return (row_of(addr) < 0) ? 1'b0 : row_wen[row_of(addr)];
  endfunction

  // ==========================================================================
  // Program
  // ==========================================================================
  task automatic build_program();
    logic [31:0] seed;
    logic [4:0]  rk;
    seed = 32'h4903_cff5;
    add_row("addi pos", asm_i(OPC_OP_IMM, 5'd1, 3'b000, 5'd0, 12'd5), 1'b1);
    add_row("addi neg", asm_i(OPC_OP_IMM, 5'd2, 3'b000, 5'd0, 12'hffd), 1'b1);
    add_row("add", asm_r(7'b0000000, 5'd3, 5'd1, 5'd2), 1'b1);
    add_row("sub", asm_r(7'b0100000, 5'd4, 5'd1, 5'd2), 1'b1);
    add_row("addi to x0", asm_i(OPC_OP_IMM, 5'd0, 3'b000, 5'd1, 12'd7), 1'b1);
    add_row("add reads x0", asm_r(7'b0000000, 5'd5, 5'd0, 5'd1), 1'b1);
    for (int k = 0; k < 8; k++) begin
      seed = lcg_next(seed);
      rk   = 5'd10 + k[4:0];
      add_row($sformatf("lcg addi %0d", k),
              asm_i(OPC_OP_IMM, rk + 5'd1, 3'b000, rk, seed[27:16]), 1'b1);
    end
    add_row("lui neg", asm_u(OPC_LUI, 5'd20, 20'h80000), 1'b1);
    add_row("lui pos", asm_u(OPC_LUI, 5'd21, 20'h12345), 1'b1);
    add_row("auipc neg", asm_u(OPC_AUIPC, 5'd22, 20'hfffff), 1'b1);
    add_row("auipc pos", asm_u(OPC_AUIPC, 5'd23, 20'h00001), 1'b1);
    add_row("jal fwd", asm_jal(5'd1, 21'd8), 1'b1);                    // Skips one word
    add_row("skipped by jal", asm_i(OPC_OP_IMM, 5'd24, 3'b000, 5'd0, 12'd99), 1'b1);
    add_row("unknown slli", asm_i(OPC_OP_IMM, 5'd24, 3'b001, 5'd1, 12'd1), 1'b0);
    add_row("auipc base", asm_u(OPC_AUIPC, 5'd25, 20'h00000), 1'b1);
    add_row("jalr odd", asm_i(OPC_JALR, 5'd26, 3'b000, 5'd25, 12'd13), 1'b1);
    add_row("skipped by jalr", asm_i(OPC_OP_IMM, 5'd24, 3'b000, 5'd0, 12'd77), 1'b1);
    add_row("jal fwd far", asm_jal(5'd28, 21'd12), 1'b1);
    add_row("set a0", asm_i(OPC_OP_IMM, 5'd10, 3'b000, 5'd3, 12'd40), 1'b1);
    add_row("ebreak", EBREAK_WORD, 1'b0);
    add_row("jal back", asm_jal(5'd0, 21'h1ffff8), 1'b1);                // Also the frozen PC
  endtask

  // ==========================================================================
  // Reference model
  // ==========================================================================
  task automatic predict(input logic [31:0] w, input bit wen);
    logic [`NPC_XLEN-1:0] rs1v;
    logic [`NPC_XLEN-1:0] rs2v;
    logic [`NPC_XLEN-1:0] imm_i;
    logic [`NPC_XLEN-1:0] imm_u;
    logic [`NPC_XLEN-1:0] imm_j;
    rs1v  = m_regs[w[19:15]];
    rs2v  = m_regs[w[24:20]];
    imm_i = {{52{w[31]}}, w[31:20]};
    imm_u = {{32{w[31]}}, w[31:12], 12'h000};
    imm_j = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    exp_valid  = wen && !m_halt;
    exp_rd     = w[11:7];
    exp_data   = '0;
    exp_next   = m_pc + 64'd4;
    exp_ebreak = 1'b0;
    case (w[6:0])
      OPC_OP_IMM: exp_data = rs1v + imm_i;
      OPC_OP:     exp_data = w[30] ? rs1v - rs2v : rs1v + rs2v;
      OPC_LUI:    exp_data = imm_u;
      OPC_AUIPC:  exp_data = m_pc + imm_u;
      OPC_JAL: begin
        exp_data = m_pc + 64'd4;
        exp_next = m_pc + imm_j;
      end
      OPC_JALR: begin
        exp_data = m_pc + 64'd4;
        exp_next = (rs1v + imm_i) & ~64'd1;
      end
      OPC_SYSTEM: exp_ebreak = (w == EBREAK_WORD);
      default: ;
    endcase
  endtask

  task automatic commit();
    bit was_halted;
    was_halted = m_halt;
    if (exp_valid && exp_rd != 5'd0) m_regs[exp_rd] = exp_data;
    if (!was_halted) begin
      m_pc = exp_next;                                   // ebreak still steps by four
      if (exp_ebreak) begin
        m_halt      = 1'b1;
        m_halt_code = m_regs[`NPC_HALT_REG];
      end
    end
  endtask

  // ==========================================================================
  // Checks
  // ==========================================================================
  task automatic flag_mismatch(input string test, input string what,
                               input logic [63:0] expv, input logic [63:0] actv);
    mismatches++;
    $display("ERR %s: %s expected %h, actual %h", test, what, expv, actv);
  endtask

  task automatic check_cycle(input string name);
    assert (inst_addr === m_pc) else flag_mismatch(name, "inst_addr", m_pc, inst_addr);
    assert (wb.valid === exp_valid) else flag_mismatch(name, "wb.valid", exp_valid, wb.valid);
    if (exp_valid) begin
      assert (wb.rd === exp_rd) else flag_mismatch(name, "wb.rd", exp_rd, wb.rd);
      assert (wb.data === exp_data) else flag_mismatch(name, "wb.data", exp_data, wb.data);
    end
    assert (halt === m_halt) else flag_mismatch(name, "halt", m_halt, halt);
    assert (halt_code === m_halt_code)
      else flag_mismatch(name, "halt_code", m_halt_code, halt_code);
  endtask

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    build_program();
    for (int i = 0; i < 32; i++) m_regs[i] = '0;
    m_pc        = `NPC_RESET_PC;
    m_halt      = 1'b0;
    m_halt_code = '0;
    inst        = word_at(m_pc);
    limit       = 2 * row_inst.size() + 20;

    repeat (5) @(negedge clk);
    assert (inst_addr === `NPC_RESET_PC)
      else flag_mismatch("reset", "inst_addr", `NPC_RESET_PC, inst_addr);
    assert (halt === 1'b0) else flag_mismatch("reset", "halt", 1'b0, halt);
    assert (halt_code === '0) else flag_mismatch("reset", "halt_code", '0, halt_code);
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    while (!finished && cycles < limit) begin
      predict(inst, wen_at(m_pc));
      check_cycle(m_halt ? "halt hold" : name_at(m_pc));
      if (halt === 1'b1) hold_cnt++;                      // Run ends on the core's own halt
      if (hold_cnt >= HOLD_CYCLES) begin
        finished = 1'b1;
      end else begin
        @(posedge clk);
        commit();
        inst <= word_at(m_pc);                              // Next fetch from the model PC
        cycles++;
        @(negedge clk);
      end
    end

    if (!finished) begin
      others++;
      $display("Timeout: the core did not halt within %0d cycles", limit);
    end
    $display("Mismatches: %0d, other failures: %0d, cycles: %0d", mismatches, others, cycles);
    if (mismatches == 0 && others == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
rv_isa_pkg.sv
npc_ctrl_pkg.sv
npc_ifu.sv
npc_idu.sv
npc_regfile.sv
npc_exu.sv
npc_wbu.sv
npc_top.sv
tb_npc_top.sv

// File: Bender.yml
package:
  name: npc_core

export_include_dirs:
  - .

sources:
  - rv_isa_pkg.sv
  - npc_ctrl_pkg.sv
  - npc_ifu.sv
  - npc_idu.sv
  - npc_regfile.sv
  - npc_exu.sv
  - npc_wbu.sv
  - npc_top.sv
  - target: simulation
    files:
      - tb_npc_top.sv
